// ==== Bender.yml ====
package:
  name: csi_rx

sources:
  - csi_rx_pkg.sv
  - csi_header_decode.sv
  - csi_packet_exec.sv
  - csi_frame_writer.sv
  - csi_rx_top.sv
  - target: test
    files:
      - csi_rx_properties.sv
      - csi_rx_tb.sv

// ==== csi_frame_writer.sv ====
module csi_frame_writer #(
	parameter int unsigned LINE_WORDS = 160
) (
	input  logic                    mipi_clk_2,
	input  logic                    reset,
	input  csi_rx_pkg::pixel_word_t pixel_i,
	output logic                    wb_cyc_o,
	output logic                    wb_stb_o,
	output logic                    wb_we_o,
	output csi_rx_pkg::addr_t       wb_adr_o,
	output csi_rx_pkg::word_t       wb_dat_o,
	input  logic                    wb_ack_i,
	output csi_rx_pkg::count_t      dropped_o
);
	import csi_rx_pkg::*;

	addr_t word_addr_w;
	logic  accept_w;

	////////////////////////////////////////////////////////////
	// address generation

	// line-major layout, LINE_WORDS words per line
	assign word_addr_w = addr_t'(pixel_i.line) * addr_t'(LINE_WORDS) +
		addr_t'(pixel_i.index);

	// a new word only starts a cycle when nothing is pending
	assign accept_w = pixel_i.valid && !wb_cyc_o;

	////////////////////////////////////////////////////////////
	// wishbone classic write master

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			wb_cyc_o  <= 1'b0;
			wb_stb_o  <= 1'b0;
			wb_we_o   <= 1'b0;
			dropped_o <= '0;
		end else begin
			if (accept_w) begin
				wb_cyc_o <= 1'b1;
				wb_stb_o <= 1'b1;
				wb_we_o  <= 1'b1;
			end else if (wb_cyc_o && wb_ack_i) begin
				// slave took the word, release the bus
				wb_cyc_o <= 1'b0;
				wb_stb_o <= 1'b0;
				wb_we_o  <= 1'b0;
			end
			// stream cannot stall, so a word that finds the
			// writer busy is lost and counted
			if (pixel_i.valid && wb_cyc_o) begin
				dropped_o <= dropped_o + 1'b1;
			end
		end
		// address and data stay put until the next accepted word
		if (accept_w) begin
			wb_adr_o <= word_addr_w;
			wb_dat_o <= pixel_i.data;
		end
	end

endmodule

// ==== csi_header_decode.sv ====
module csi_header_decode (
	input  logic                   mipi_clk_2,
	input  logic                   reset,
	input  csi_rx_pkg::lane_pair_t lane_pair_i,
	input  logic                   in_packet_i,
	output csi_rx_pkg::header_t    header_o,
	output csi_rx_pkg::payload_t   payload_o,
	output logic                   header_error_o,
	output logic                   header_fixed_o
);
	import csi_rx_pkg::*;

	// check-matrix column of each header bit; a single flipped
	// bit produces exactly its own column as syndrome
	localparam logic [5:0] ECC_COL [24] = '{
		6'h07, 6'h0b, 6'h0d, 6'h0e, 6'h13, 6'h15, 6'h16, 6'h19,
		6'h1a, 6'h1c, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2a, 6'h2c,
		6'h31, 6'h32, 6'h34, 6'h38, 6'h1f, 6'h2f, 6'h37, 6'h3b
	};

	logic        phase_q;
	logic        first_q;
	logic        drop_q;
	logic [15:0] low_q;
	word_t       word_w;
	logic [5:0]  ecc_w;
	logic [7:0]  syndrome_w;
	logic [23:0] flip_w;
	logic [23:0] fixed_w;
	logic        ecc_only_w;
	logic        bad_w;
	logic        take_w;

	////////////////////////////////////////////////////////////
	// word assembly

	// second pair of a word completes it
	assign take_w = in_packet_i && lane_pair_i.valid && phase_q;
	assign word_w = {lane_pair_i.byte1, lane_pair_i.byte0, low_q};

	always_ff @(posedge mipi_clk_2) begin
		if (lane_pair_i.valid && !phase_q) begin
			low_q <= {lane_pair_i.byte1, lane_pair_i.byte0};
		end
	end

	////////////////////////////////////////////////////////////
	// header ecc

	always_comb begin
		ecc_w  = '0;
		flip_w = '0;
		for (int i = 0; i < 24; i++) begin
			if (word_w[i]) begin
				ecc_w = ecc_w ^ ECC_COL[i];
			end
		end
		syndrome_w = {2'b00, ecc_w} ^ word_w[31:24];
		for (int i = 0; i < 24; i++) begin
			if (syndrome_w == {2'b00, ECC_COL[i]}) begin
				flip_w[i] = 1'b1;
			end
		end
	end

	// error sits in the ecc byte itself, header bits are intact
	assign ecc_only_w = (syndrome_w[7:6] == 2'b00) && $onehot(syndrome_w[5:0]);
	assign bad_w      = (syndrome_w != '0) && (flip_w == '0) && !ecc_only_w;
	assign fixed_w    = word_w[23:0] ^ flip_w;

	////////////////////////////////////////////////////////////
	// burst sequencing

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !in_packet_i) begin
			phase_q <= 1'b0;
			first_q <= 1'b1;
			drop_q  <= 1'b0;
		end else if (lane_pair_i.valid) begin
			phase_q <= !phase_q;
			if (phase_q) begin
				first_q <= 1'b0;
				// rest of the burst is untrusted
				if (first_q && bad_w) begin
					drop_q <= 1'b1;
				end
			end
		end
	end

	// outputs, one cycle after the completing pair
	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			header_o.valid  <= 1'b0;
			payload_o.valid <= 1'b0;
			header_error_o  <= 1'b0;
			header_fixed_o  <= 1'b0;
		end else begin
			header_o.valid  <= take_w && first_q && !bad_w;
			payload_o.valid <= take_w && !first_q && !drop_q;
			header_error_o  <= take_w && first_q && bad_w;
			header_fixed_o  <= take_w && first_q && !bad_w && (syndrome_w != '0);
		end
		header_o.dtype     <= fixed_w[5:0];
		header_o.wcount    <= fixed_w[23:8];
		header_o.corrected <= syndrome_w != '0;
		payload_o.data     <= word_w;
	end

endmodule

// ==== csi_packet_exec.sv ====
module csi_packet_exec #(
	parameter int unsigned LINE_WORDS  = 160,
	parameter int unsigned FRAME_LINES = 480
) (
	input  logic                    mipi_clk_2,
	input  logic                    reset,
	input  logic                    in_packet_i,
	input  csi_rx_pkg::header_t     header_i,
	input  csi_rx_pkg::payload_t    payload_i,
	output csi_rx_pkg::pixel_word_t pixel_o,
	output logic                    line_done_o,
	output logic                    crc_ok_o
);
	import csi_rx_pkg::*;

	localparam word_count_t LINE_BYTES = word_count_t'(LINE_WORDS * 4);
	localparam count_t      LAST_INDEX = count_t'(LINE_WORDS - 1);
	localparam count_t      MAX_LINES  = count_t'(FRAME_LINES);
	localparam crc_t        CRC_INIT   = 16'hffff;
	// reflected form of x^16 + x^12 + x^5 + 1
	localparam crc_t        CRC_POLY   = 16'h8408;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LINE,
		ST_CRC_WAIT
	} state_t;

	state_t state_q;
	count_t line_q;
	count_t index_q;
	crc_t   crc_q;
	logic   frame_mark_w;
	logic   line_start_w;

	////////////////////////////////////////////////////////////
	// crc-16 over one word

	// bytes go low first and each byte lsb first, so the word
	// is simply walked from bit 0 upward
	function automatic crc_t crc16_word(input crc_t crc_in, input word_t data);
		crc_t crc;
		logic fb;
		crc = crc_in;
		for (int i = 0; i < WORD_W; i++) begin
			fb  = crc[0] ^ data[i];
			crc = crc >> 1;
			if (fb) begin
				crc = crc ^ CRC_POLY;
			end
		end
		return crc;
	endfunction

	////////////////////////////////////////////////////////////
	// header classification

	assign frame_mark_w = header_i.valid &&
		(header_i.dtype == DT_FRAME_START || header_i.dtype == DT_FRAME_END);

	// only full raw8 lines inside the frame are taken
	assign line_start_w = header_i.valid && (header_i.dtype == DT_RAW8) &&
		(header_i.wcount == LINE_BYTES) && (line_q < MAX_LINES);

	////////////////////////////////////////////////////////////
	// packet fsm

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			state_q       <= ST_IDLE;
			line_q        <= '0;
			pixel_o.valid <= 1'b0;
			line_done_o   <= 1'b0;
			crc_ok_o      <= 1'b0;
		end else begin
			pixel_o.valid <= 1'b0;
			line_done_o   <= 1'b0;
			crc_ok_o      <= 1'b0;
			if (!in_packet_i) begin
				state_q <= ST_IDLE;
			end else begin
				case (state_q)
					ST_IDLE: begin
						if (frame_mark_w) begin
							line_q <= '0;
						end
						if (line_start_w) begin
							state_q <= ST_LINE;
						end
					end
					ST_LINE: begin
						if (payload_i.valid) begin
							pixel_o.valid <= 1'b1;
							if (index_q == LAST_INDEX) begin
								state_q <= ST_CRC_WAIT;
							end
						end
					end
					ST_CRC_WAIT: begin
						// crc sits in the low half, upper half is padding
						if (payload_i.valid) begin
							line_done_o <= 1'b1;
							crc_ok_o    <= payload_i.data[15:0] == crc_q;
							line_q      <= line_q + 1'b1;
							state_q     <= ST_IDLE;
						end
					end
					default: begin
						state_q <= ST_IDLE;
					end
				endcase
			end
		end
		// running crc and word index of the current line
		if (state_q == ST_IDLE) begin
			index_q <= '0;
			crc_q   <= CRC_INIT;
		end else if (state_q == ST_LINE && payload_i.valid) begin
			index_q <= index_q + 1'b1;
			crc_q   <= crc16_word(crc_q, payload_i.data);
		end
		pixel_o.data  <= payload_i.data;
		pixel_o.line  <= line_q;
		pixel_o.index <= index_q;
	end

endmodule

// ==== csi_rx_pkg.sv ====
package csi_rx_pkg;

	////////////////////////////////////////////////////////////
	// widths

	localparam int BYTE_W  = 8;
	localparam int WORD_W  = 32;
	localparam int DT_W    = 6;
	localparam int WC_W    = 16;
	localparam int CRC_W   = 16;
	localparam int ADDR_W  = 32;
	localparam int COUNT_W = 16;

	////////////////////////////////////////////////////////////
	// data types

	// one byte as it comes off a lane
	typedef logic [BYTE_W-1:0] byte_t;

	// lane 0 in the low byte of each pair, first pair in the low half
	typedef logic [WORD_W-1:0] word_t;

	typedef logic [DT_W-1:0]    data_type_t;
	typedef logic [WC_W-1:0]    word_count_t;
	typedef logic [CRC_W-1:0]   crc_t;
	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [COUNT_W-1:0] count_t;

	////////////////////////////////////////////////////////////
	// data identifiers

	localparam data_type_t DT_FRAME_START = 6'h00;
	localparam data_type_t DT_FRAME_END   = 6'h01;
	localparam data_type_t DT_RAW8        = 6'h2a;

	////////////////////////////////////////////////////////////
	// stage records

	// one byte pair per clock from the aligned lanes
	typedef struct packed {
		byte_t byte0;
		byte_t byte1;
		logic  valid;
	} lane_pair_t;

	typedef struct packed {
		data_type_t  dtype;
		word_count_t wcount;
		logic        corrected;
		logic        valid;
	} header_t;

	typedef struct packed {
		word_t data;
		logic  valid;
	} payload_t;

	// payload word tagged with its place in the frame
	typedef struct packed {
		word_t  data;
		count_t line;
		count_t index;
		logic   valid;
	} pixel_word_t;

endpackage

// ==== csi_rx_properties.sv ====
module csi_rx_properties (
	input logic              mipi_clk_2,
	input logic              reset,
	input logic              wb_cyc_i,
	input logic              wb_stb_i,
	input logic              wb_ack_i,
	input csi_rx_pkg::addr_t wb_adr_i,
	input csi_rx_pkg::word_t wb_dat_i,
	input logic              line_done_i,
	input logic              crc_ok_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// assertion failures of this instance
	int unsigned failures;

	initial failures = 0;

	stb_in_cyc: assert property (@(posedge mipi_clk_2) disable iff (reset)
		wb_stb_i |-> wb_cyc_i)
		else begin
			$error("wb_stb_o high outside a bus cycle");
			failures++;
		end

	// classic cycle holds address and data until ack
	stb_hold_stable: assert property (@(posedge mipi_clk_2) disable iff (reset)
		wb_stb_i && !wb_ack_i |=> $stable(wb_adr_i) && $stable(wb_dat_i))
		else begin
			$error("wb_adr_o or wb_dat_o changed before ack");
			failures++;
		end

	crc_ok_with_done: assert property (@(posedge mipi_clk_2) disable iff (reset)
		crc_ok_i |-> line_done_i)
		else begin
			$error("crc_ok_o high without line_done_o");
			failures++;
		end

endmodule

bind csi_frame_writer csi_rx_properties i_wb_properties (
	.mipi_clk_2  (mipi_clk_2),
	.reset       (reset),
	.wb_cyc_i    (wb_cyc_o),
	.wb_stb_i    (wb_stb_o),
	.wb_ack_i    (wb_ack_i),
	.wb_adr_i    (wb_adr_o),
	.wb_dat_i    (wb_dat_o),
	.line_done_i (1'b0),
	.crc_ok_i    (1'b0)
);

bind csi_packet_exec csi_rx_properties i_line_properties (
	.mipi_clk_2  (mipi_clk_2),
	.reset       (reset),
	.wb_cyc_i    (1'b0),
	.wb_stb_i    (1'b0),
	.wb_ack_i    (1'b0),
	.wb_adr_i    ('0),
	.wb_dat_i    ('0),
	.line_done_i (line_done_o),
	.crc_ok_i    (crc_ok_o)
);

// ==== csi_rx_tb.sv ====
module csi_rx_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import csi_rx_pkg::*;

	localparam int          LINE_WORDS  = 8;
	localparam int          FRAME_LINES = 4;
	localparam int          WAIT_LIMIT  = 2000;
	localparam word_count_t LINE_BYTES  = LINE_WORDS * 4;

	logic       mipi_clk_2;
	logic       reset;
	lane_pair_t lane_pair_i;
	logic       in_packet_i;
	logic       wb_cyc_o;
	logic       wb_stb_o;
	logic       wb_we_o;
	addr_t      wb_adr_o;
	word_t      wb_dat_o;
	logic       wb_ack_i;
	logic       line_done_o;
	logic       crc_ok_o;
	logic       header_error_o;
	logic       header_fixed_o;
	count_t     dropped_o;

	// slave model and pulse monitors
	int          ack_delay;
	logic        ack_hold;
	int          ack_wait;
	addr_t       wr_adr_q[$];
	word_t       wr_dat_q[$];
	int          fixed_cnt;
	int          error_cnt;
	int          done_cnt;
	int          crc_ok_cnt;
	word_t       burst_q[$];
	word_t       expect_q[$];
	logic [31:0] rng_state;
	int          errors;
	int          test_errors;
	int          tests_failed;

	csi_rx_top #(
		.LINE_WORDS  (LINE_WORDS),
		.FRAME_LINES (FRAME_LINES)
	) i_csi_rx_top (.*);

	initial begin
		mipi_clk_2 = 1'b0;
		forever #10 mipi_clk_2 = ~mipi_clk_2;
	end

	////////////////////////////////////////////////////////////
	// wishbone slave that acks after ack_delay cycles of strobe
	always @(negedge mipi_clk_2) begin
		if (wb_ack_i) begin
			wb_ack_i = 1'b0;
			ack_wait = 0;
		end else if (wb_cyc_o && wb_stb_o && !ack_hold) begin
			if (ack_wait >= ack_delay) begin
				wb_ack_i = 1'b1;
				wr_adr_q.push_back(wb_adr_o);
				wr_dat_q.push_back(wb_dat_o);
				if (!wb_we_o) begin
					report_mismatch("bus cycle without wb_we_o");
				end
			end else begin
				ack_wait++;
			end
		end
		fixed_cnt  += header_fixed_o;
		error_cnt  += header_error_o;
		done_cnt   += line_done_o;
		crc_ok_cnt += crc_ok_o;
	end

	////////////////////////////////////////////////////////////
	// reference models
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// csi-2 parity equations with one data mask per ecc bit
	function automatic logic [5:0] header_ecc(input logic [23:0] d);
		logic [5:0] p;
		p[0] = ^(d & 24'hf12cb7);
		p[1] = ^(d & 24'hf2555b);
		p[2] = ^(d & 24'h749a6d);
		p[3] = ^(d & 24'hb8e38e);
		p[4] = ^(d & 24'hdf03f0);
		p[5] = ^(d & 24'heffc00);
		return p;
	endfunction

	function automatic word_t make_header(input data_type_t dt, input word_count_t wc);
		logic [23:0] d;
		d = {wc, 2'b00, dt};
		return {2'b00, header_ecc(d), d};
	endfunction

	function automatic crc_t crc_byte(input crc_t crc, input byte_t b);
		for (int i = 0; i < 8; i++) begin
			if (crc[0] ^ b[i]) begin
				crc = (crc >> 1) ^ 16'h8408;
			end else begin
				crc = crc >> 1;
			end
		end
		return crc;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		test_errors++;
	endtask

	// header, random payload, then crc word with padded upper half
	task automatic build_line(input word_t hdr, input logic corrupt);
		crc_t  crc;
		word_t w;
		crc = 16'hffff;
		burst_q = {hdr};
		expect_q = {};
		for (int i = 0; i < LINE_WORDS; i++) begin
			rng_state = xorshift(rng_state);
			w = rng_state;
			burst_q.push_back(w);
			expect_q.push_back(w);
			for (int b = 0; b < 4; b++) begin
				crc = crc_byte(crc, w[8*b +: 8]);
			end
		end
		if (corrupt) begin
			crc = crc ^ 16'h0100;
		end
		burst_q.push_back({16'h0000, crc});
	endtask

	task automatic send_pair(input logic [15:0] p);
		@(negedge mipi_clk_2);
		lane_pair_i = '{byte0: p[7:0], byte1: p[15:8], valid: 1'b1};
	endtask

	task automatic send_burst();
		@(negedge mipi_clk_2);
		in_packet_i = 1'b1;
		foreach (burst_q[i]) begin
			send_pair(burst_q[i][15:0]);
			send_pair(burst_q[i][31:16]);
		end
		@(negedge mipi_clk_2);
		lane_pair_i.valid = 1'b0;
		// let the last word leave decode before the burst closes
		repeat (4) @(negedge mipi_clk_2);
		in_packet_i = 1'b0;
		repeat (2) @(negedge mipi_clk_2);
	endtask

	task automatic send_short(input data_type_t dt);
		burst_q = {make_header(dt, 16'h0000)};
		send_burst();
	endtask

	task automatic wait_writes(input int n);
		int cycles;
		cycles = 0;
		while (wr_adr_q.size() < n && cycles < WAIT_LIMIT) begin
			@(negedge mipi_clk_2);
			cycles++;
		end
		if (wr_adr_q.size() < n) begin
			$display("timeout: only %0d of %0d writes arrived", wr_adr_q.size(), n);
			$display("SOME TESTS FAILED");
			$finish;
		end
	endtask

	task automatic wait_bus_idle();
		int cycles;
		cycles = 0;
		while (wb_cyc_o && cycles < WAIT_LIMIT) begin
			@(negedge mipi_clk_2);
			cycles++;
		end
		if (wb_cyc_o) begin
			$display("timeout: the bus cycle never ended");
			$display("SOME TESTS FAILED");
			$finish;
		end
	endtask

	task automatic check_writes(input int first, input int base);
		for (int i = 0; i < expect_q.size(); i++) begin
			if (wr_adr_q[first+i] != addr_t'(base + i)) begin
				report_mismatch($sformatf("write %0d at %0h, expected %0h", first + i,
					wr_adr_q[first+i], base + i));
			end
			if (wr_dat_q[first+i] != expect_q[i]) begin
				report_mismatch($sformatf("write %0d data %h, expected %h", first + i,
					wr_dat_q[first+i], expect_q[i]));
			end
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s", name, (test_errors == 0) ? "ok" : "failed");
		if (test_errors != 0) begin
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	task automatic test_reset_state();
		if (wb_cyc_o || wb_stb_o) begin
			report_mismatch("bus active after reset");
		end
		if (line_done_o || crc_ok_o || header_error_o || header_fixed_o) begin
			report_mismatch("status pulse after reset");
		end
		if (dropped_o != 0) begin
			report_mismatch($sformatf("dropped_o %0d after reset", dropped_o));
		end
		end_test("reset state");
	endtask

	task automatic test_clean_lines();
		int first;
		int d0;
		int c0;
		first = wr_adr_q.size();
		d0 = done_cnt;
		c0 = crc_ok_cnt;
		send_short(DT_FRAME_START);
		for (int l = 0; l < 2; l++) begin
			build_line(make_header(DT_RAW8, LINE_BYTES), 1'b0);
			send_burst();
			wait_writes(first + LINE_WORDS * (l + 1));
			check_writes(first + LINE_WORDS * l, LINE_WORDS * l);
		end
		wait_bus_idle();
		if (wr_adr_q.size() - first != 2 * LINE_WORDS) begin
			report_mismatch($sformatf("%0d writes, expected 16", wr_adr_q.size() - first));
		end
		if (done_cnt - d0 != 2 || crc_ok_cnt - c0 != 2) begin
			report_mismatch("expected two line_done pulses with crc_ok");
		end
		end_test("two clean lines");
	endtask

	task automatic test_header_ecc();
		int first;
		int f0;
		int e0;
		int c0;
		first = wr_adr_q.size();
		f0 = fixed_cnt;
		e0 = error_cnt;
		c0 = crc_ok_cnt;
		send_short(DT_FRAME_START);
		// one flipped word-count bit is repaired
		build_line(make_header(DT_RAW8, LINE_BYTES) ^ 32'h0000_0400, 1'b0);
		send_burst();
		wait_writes(first + LINE_WORDS);
		check_writes(first, 0);
		if (fixed_cnt - f0 != 1 || crc_ok_cnt - c0 != 1) begin
			report_mismatch("single-bit header error not fixed");
		end
		// two flipped bits cannot be repaired
		build_line(make_header(DT_RAW8, LINE_BYTES) ^ 32'h0000_0003, 1'b0);
		send_burst();
		wait_bus_idle();
		if (error_cnt - e0 != 1 || fixed_cnt - f0 != 1) begin
			report_mismatch("double-bit header error not flagged");
		end
		if (wr_adr_q.size() != first + LINE_WORDS) begin
			report_mismatch("writes after an uncorrectable header");
		end
		end_test("header ecc");
	endtask

	task automatic test_bad_crc();
		int first;
		int d0;
		int c0;
		first = wr_adr_q.size();
		d0 = done_cnt;
		c0 = crc_ok_cnt;
		send_short(DT_FRAME_START);
		build_line(make_header(DT_RAW8, LINE_BYTES), 1'b1);
		send_burst();
		wait_writes(first + LINE_WORDS);
		check_writes(first, 0);
		if (done_cnt - d0 != 1 || crc_ok_cnt != c0) begin
			report_mismatch("bad crc not reported on line_done");
		end
		end_test("corrupted crc");
	endtask

	task automatic test_ack_withheld();
		int     first;
		count_t drop0;
		first = wr_adr_q.size();
		drop0 = dropped_o;
		send_short(DT_FRAME_START);
		ack_hold = 1'b1;
		build_line(make_header(DT_RAW8, LINE_BYTES), 1'b0);
		send_burst();
		if (!wb_cyc_o || !wb_stb_o || wr_adr_q.size() != first) begin
			report_mismatch("expected one write pending");
		end
		if (dropped_o - drop0 != LINE_WORDS - 1) begin
			report_mismatch($sformatf("dropped_o rose by %0d, expected 7", dropped_o - drop0));
		end
		// pending word is released with a slow ack
		ack_delay = 3;
		ack_hold = 1'b0;
		wait_writes(first + 1);
		wait_bus_idle();
		ack_delay = 0;
		expect_q = {expect_q[0]};
		check_writes(first, 0);
		// a new frame restarts at address 0
		send_short(DT_FRAME_START);
		build_line(make_header(DT_RAW8, LINE_BYTES), 1'b0);
		send_burst();
		wait_writes(first + 1 + LINE_WORDS);
		check_writes(first + 1, 0);
		end_test("ack withheld");
	endtask

	task automatic test_ignored_headers();
		int first;
		int d0;
		first = wr_adr_q.size();
		send_short(DT_FRAME_START);
		build_line(make_header(6'h2b, LINE_BYTES), 1'b0);
		send_burst();
		build_line(make_header(DT_RAW8, LINE_BYTES - 4), 1'b0);
		send_burst();
		wait_bus_idle();
		if (wr_adr_q.size() != first) begin
			report_mismatch("writes for a foreign data type or word count");
		end
		d0 = done_cnt;
		for (int l = 0; l <= FRAME_LINES; l++) begin
			build_line(make_header(DT_RAW8, LINE_BYTES), 1'b0);
			send_burst();
			if (l < FRAME_LINES) begin
				wait_writes(first + LINE_WORDS * (l + 1));
				check_writes(first + LINE_WORDS * l, LINE_WORDS * l);
			end
		end
		wait_bus_idle();
		if (wr_adr_q.size() != first + LINE_WORDS * FRAME_LINES || done_cnt - d0 != 4) begin
			report_mismatch("line beyond the frame was taken");
		end
		end_test("ignored headers");
	endtask

	initial begin
		reset = 1'b1;
		in_packet_i = 1'b0;
		lane_pair_i = '0;
		wb_ack_i = 1'b0;
		ack_delay = 0;
		ack_hold = 1'b0;
		ack_wait = 0;
		fixed_cnt = 0;
		error_cnt = 0;
		done_cnt = 0;
		crc_ok_cnt = 0;
		rng_state = 32'd7;
		errors = 0;
		test_errors = 0;
		tests_failed = 0;
		repeat (16) @(negedge mipi_clk_2);
		reset = 1'b0;
		test_reset_state();
		test_clean_lines();
		test_header_ecc();
		test_bad_crc();
		test_ack_withheld();
		test_ignored_headers();
		errors += i_csi_rx_top.i_csi_frame_writer.i_wb_properties.failures;
		errors += i_csi_rx_top.i_csi_packet_exec.i_line_properties.failures;
		$display("tests run 6, failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== csi_rx_top.sv ====
module csi_rx_top #(
	parameter int unsigned LINE_WORDS  = 160,
	parameter int unsigned FRAME_LINES = 480
) (
	input  logic                   mipi_clk_2,
	input  logic                   reset,
	input  csi_rx_pkg::lane_pair_t lane_pair_i,
	input  logic                   in_packet_i,
	output logic                   wb_cyc_o,
	output logic                   wb_stb_o,
	output logic                   wb_we_o,
	output csi_rx_pkg::addr_t      wb_adr_o,
	output csi_rx_pkg::word_t      wb_dat_o,
	input  logic                   wb_ack_i,
	output logic                   line_done_o,
	output logic                   crc_ok_o,
	output logic                   header_error_o,
	output logic                   header_fixed_o,
	output csi_rx_pkg::count_t     dropped_o
);
	import csi_rx_pkg::*;

	header_t     header_w;
	payload_t    payload_w;
	pixel_word_t pixel_w;

	// pairs to words, header check
	csi_header_decode i_csi_header_decode (
		.mipi_clk_2     (mipi_clk_2),
		.reset          (reset),
		.lane_pair_i    (lane_pair_i),
		.in_packet_i    (in_packet_i),
		.header_o       (header_w),
		.payload_o      (payload_w),
		.header_error_o (header_error_o),
		.header_fixed_o (header_fixed_o)
	);

	// line tracking and crc
	csi_packet_exec #(
		.LINE_WORDS  (LINE_WORDS),
		.FRAME_LINES (FRAME_LINES)
	) i_csi_packet_exec (
		.mipi_clk_2  (mipi_clk_2),
		.reset       (reset),
		.in_packet_i (in_packet_i),
		.header_i    (header_w),
		.payload_i   (payload_w),
		.pixel_o     (pixel_w),
		.line_done_o (line_done_o),
		.crc_ok_o    (crc_ok_o)
	);

	// frame buffer port
	csi_frame_writer #(
		.LINE_WORDS (LINE_WORDS)
	) i_csi_frame_writer (
		.mipi_clk_2 (mipi_clk_2),
		.reset      (reset),
		.pixel_i    (pixel_w),
		.wb_cyc_o   (wb_cyc_o),
		.wb_stb_o   (wb_stb_o),
		.wb_we_o    (wb_we_o),
		.wb_adr_o   (wb_adr_o),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_i   (wb_ack_i),
		.dropped_o  (dropped_o)
	);

endmodule

// ==== src.f ====
csi_rx_pkg.sv
csi_header_decode.sv
csi_packet_exec.sv
csi_frame_writer.sv
csi_rx_top.sv
csi_rx_properties.sv
csi_rx_tb.sv
